//--- verilog/hwpf_pkg.sv
/*
 * Hardware stride prefetcher shared definitions
 * Sizes, the 64-bit configuration word with its three register views,
 * and the snoop, trigger and prefetch request records
 */
package hwpf_pkg;

  localparam int NR_ENGINES    = 4;
  localparam int ENGINE_ID_W   = 2;
  localparam int ADDR_W        = 32;
  localparam int LINE_OFFSET_W = 6;
  localparam int LINE_W        = ADDR_W - LINE_OFFSET_W;
  localparam int FIFO_DEPTH    = 4;
  localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);
  localparam int DROP_CNT_W    = 8;

  typedef enum logic [1:0] {
    CFG_BASE     = 2'd0,
    CFG_PARAM    = 2'd1,
    CFG_THROTTLE = 2'd2
  } cfg_kind_e;

  typedef struct packed {
    logic [31:0]       unused_hi;
    logic [LINE_W-1:0] base_line;
    logic [4:0]        unused_lo;
    logic              enable;
  } base_word_t;

  typedef struct packed {
    logic [31:0] unused;
    logic [15:0] nlines;
    logic [15:0] stride;
  } param_word_t;

  typedef struct packed {
    logic [47:0] unused;
    logic [15:0] nwait;
  } throttle_word_t;

  // One written word, read as the register its kind selects
  typedef union packed {
    base_word_t     base;
    param_word_t    param;
    throttle_word_t throttle;
  } cfg_word_u;

  typedef struct packed {
    logic                   valid;
    logic [ENGINE_ID_W-1:0] engine;
    cfg_kind_e              kind;
    cfg_word_u              data;
  } cfg_wr_t;

  typedef struct packed {
    logic              enable;
    logic [LINE_W-1:0] base_line;
    logic [15:0]       stride;
    logic [15:0]       nlines;
    logic [15:0]       nwait;
  } engine_cfg_t;

  typedef struct packed {
    logic              valid;
    logic              abort;
    logic [ADDR_W-1:0] addr;
  } snoop_t;

  typedef struct packed {
    logic [ENGINE_ID_W-1:0] engine;
    logic [LINE_W-1:0]      base_line;
  } trigger_t;

  typedef struct packed {
    logic                   valid;
    logic [ENGINE_ID_W-1:0] engine;
    logic [LINE_W-1:0]      line;
  } pf_req_t;

endpackage

//--- verilog/hwpf_csr.sv
/*
 * Prefetcher configuration registers
 * Base, parameter and throttle words per engine, written by a one-cycle
 * strobe and read back with unused bits cleared. Each engine's words are
 * also decoded into its working settings.
 */
`timescale 1ns/10ps

module hwpf_csr (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  hwpf_pkg::cfg_wr_t                                cfg_wr_i,
  output hwpf_pkg::cfg_word_u   [hwpf_pkg::NR_ENGINES-1:0] base_o,
  output hwpf_pkg::cfg_word_u   [hwpf_pkg::NR_ENGINES-1:0] param_o,
  output hwpf_pkg::cfg_word_u   [hwpf_pkg::NR_ENGINES-1:0] throttle_o,
  output hwpf_pkg::engine_cfg_t [hwpf_pkg::NR_ENGINES-1:0] engine_cfg_o
);
  import hwpf_pkg::*;

  cfg_word_u [NR_ENGINES-1:0] base_q;
  cfg_word_u [NR_ENGINES-1:0] param_q;
  cfg_word_u [NR_ENGINES-1:0] throttle_q;

  cfg_word_u wr_base;
  cfg_word_u wr_param;
  cfg_word_u wr_throttle;

  // Keep only the defined fields of each view
  always_comb begin
    wr_base                       = '0;
    wr_base.base.base_line        = cfg_wr_i.data.base.base_line;
    wr_base.base.enable           = cfg_wr_i.data.base.enable;
    wr_param                      = '0;
    wr_param.param.nlines         = cfg_wr_i.data.param.nlines;
    wr_param.param.stride         = cfg_wr_i.data.param.stride;
    wr_throttle                   = '0;
    wr_throttle.throttle.nwait    = cfg_wr_i.data.throttle.nwait;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q     <= '0;
      param_q    <= '0;
      throttle_q <= '0;
    end else if (cfg_wr_i.valid) begin
      case (cfg_wr_i.kind)
        CFG_BASE:     base_q[cfg_wr_i.engine]     <= wr_base;
        CFG_PARAM:    param_q[cfg_wr_i.engine]    <= wr_param;
        CFG_THROTTLE: throttle_q[cfg_wr_i.engine] <= wr_throttle;
        default: ;
      endcase
    end
  end

  assign base_o     = base_q;
  assign param_o    = param_q;
  assign throttle_o = throttle_q;

  always_comb begin
    for (int e = 0; e < NR_ENGINES; e++) begin
      engine_cfg_o[e].enable    = base_q[e].base.enable;
      engine_cfg_o[e].base_line = base_q[e].base.base_line;
      engine_cfg_o[e].stride    = param_q[e].param.stride;
      engine_cfg_o[e].nlines    = param_q[e].param.nlines;
      engine_cfg_o[e].nwait     = throttle_q[e].throttle.nwait;
    end
  end

  a_cfg_kind_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_wr_i.valid |-> cfg_wr_i.kind inside {CFG_BASE, CFG_PARAM, CFG_THROTTLE}
  ) else $error("config write with undefined kind %0d", cfg_wr_i.kind);

endmodule

//--- verilog/hwpf_snoop.sv
/*
 * Snoop matcher
 * Compares the line of each accepted load and store access with the base
 * line of every enabled engine and registers at most one trigger per
 * cycle, load port first, then lowest engine index.
 */
`timescale 1ns/10ps

module hwpf_snoop (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  hwpf_pkg::snoop_t                                 snoop_ld_i,
  input  hwpf_pkg::snoop_t                                 snoop_st_i,
  input  hwpf_pkg::engine_cfg_t [hwpf_pkg::NR_ENGINES-1:0] engine_cfg_i,
  output logic                                             trig_valid_o,
  output hwpf_pkg::trigger_t                               trig_o
);
  import hwpf_pkg::*;

  logic [NR_ENGINES-1:0]  en_vec;
  logic [NR_ENGINES-1:0]  ld_hit;
  logic [NR_ENGINES-1:0]  st_hit;
  logic                   sel_valid;
  logic [ENGINE_ID_W-1:0] sel_engine;
  logic [LINE_W-1:0]      sel_line;
  logic                   trig_valid_q;
  trigger_t               trig_q;

  function automatic logic [NR_ENGINES-1:0] match_vec(
    input snoop_t                      s,
    input engine_cfg_t [NR_ENGINES-1:0] cfg
  );
    logic [NR_ENGINES-1:0] hit;
    for (int e = 0; e < NR_ENGINES; e++) begin
      hit[e] = s.valid & ~s.abort & cfg[e].enable &
               (s.addr[ADDR_W-1:LINE_OFFSET_W] == cfg[e].base_line);
    end
    return hit;
  endfunction

  // Lowest set index wins
  function automatic logic [ENGINE_ID_W-1:0] lowest(input logic [NR_ENGINES-1:0] v);
    logic [ENGINE_ID_W-1:0] idx;
    idx = '0;
    for (int e = NR_ENGINES - 1; e >= 0; e--) begin
      if (v[e]) idx = ENGINE_ID_W'(e);
    end
    return idx;
  endfunction

  always_comb begin
    for (int e = 0; e < NR_ENGINES; e++) begin
      en_vec[e] = engine_cfg_i[e].enable;
    end
  end

  assign ld_hit    = match_vec(snoop_ld_i, engine_cfg_i);
  assign st_hit    = match_vec(snoop_st_i, engine_cfg_i);
  assign sel_valid = (|ld_hit) | (|st_hit);

  // Store match is dropped when the load port also hits
  always_comb begin
    if (|ld_hit) begin
      sel_engine = lowest(ld_hit);
      sel_line   = snoop_ld_i.addr[ADDR_W-1:LINE_OFFSET_W];
    end else begin
      sel_engine = lowest(st_hit);
      sel_line   = snoop_st_i.addr[ADDR_W-1:LINE_OFFSET_W];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trig_valid_q <= 1'b0;
    end else begin
      trig_valid_q <= sel_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      trig_q.engine    <= sel_engine;
      trig_q.base_line <= sel_line;
    end
  end

  assign trig_valid_o = trig_valid_q;
  assign trig_o       = trig_q;

  a_trig_engine_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    trig_valid_o |-> (($past(en_vec) & (NR_ENGINES'(1) << trig_o.engine)) != '0)
  ) else $error("trigger for engine %0d that was not enabled", trig_o.engine);

endmodule

//--- verilog/hwpf_trigger_fifo.sv
/*
 * Trigger queue
 * Circular buffer of pending triggers between the snoop matcher and the
 * sequencer. A push that finds the queue full with no pop in the same
 * cycle is lost and counted in a saturating drop counter.
 */
`timescale 1ns/10ps

module hwpf_trigger_fifo (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                push_i,
  input  hwpf_pkg::trigger_t                  push_data_i,
  input  logic                                pop_i,
  output hwpf_pkg::trigger_t                  head_o,
  output logic                                empty_o,
  output logic [hwpf_pkg::FIFO_CNT_W-1:0]     count_o,
  output logic [hwpf_pkg::DROP_CNT_W-1:0]     drop_cnt_o
);
  import hwpf_pkg::*;

  trigger_t [FIFO_DEPTH-1:0] mem_q;
  logic [FIFO_PTR_W-1:0]     wr_ptr_q;
  logic [FIFO_PTR_W-1:0]     rd_ptr_q;
  logic [FIFO_CNT_W-1:0]     count_q;
  logic [DROP_CNT_W-1:0]     drop_q;
  logic                      full;
  logic                      push_ok;
  logic                      push_lost;

  assign full      = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  // Slot freed by a pop can take the push in the same cycle
  assign push_ok   = push_i & (~full | pop_i);
  assign push_lost = push_i & full & ~pop_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      drop_q   <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_ok && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
      if (push_lost && (drop_q != '1)) drop_q <= drop_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign count_o    = count_q;
  assign drop_cnt_o = drop_q;

  a_no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o
  ) else $error("pop from empty trigger queue");

endmodule

//--- verilog/hwpf_sequencer.sv
/*
 * Prefetch sequencer
 * Takes one trigger at a time from the queue and expands it into nlines
 * line requests at base + k * stride, spaced nwait + 1 cycles apart.
 * Stride, count and wait are latched from the engine when the trigger
 * is popped.
 */
`timescale 1ns/10ps

module hwpf_sequencer (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  hwpf_pkg::trigger_t                               head_i,
  input  logic                                             empty_i,
  output logic                                             pop_o,
  input  hwpf_pkg::engine_cfg_t [hwpf_pkg::NR_ENGINES-1:0] engine_cfg_i,
  output logic                  [hwpf_pkg::NR_ENGINES-1:0] busy_o,
  output hwpf_pkg::pf_req_t                                pf_req_o
);
  import hwpf_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ISSUE = 2'd1,
    ST_WAIT  = 2'd2
  } seq_state_e;

  seq_state_e             state_q;
  logic [15:0]            remain_q;
  logic [15:0]            wait_q;
  logic [ENGINE_ID_W-1:0] engine_q;
  logic [15:0]            stride_q;
  logic [15:0]            nwait_q;
  logic [LINE_W-1:0]      line_q;
  engine_cfg_t            head_cfg;

  assign head_cfg = engine_cfg_i[head_i.engine];
  assign pop_o    = (state_q == ST_IDLE) & ~empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
      wait_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (pop_o) begin
            remain_q <= head_cfg.nlines;
            // Zero lines consumes the trigger without a request
            if (head_cfg.nlines != '0) state_q <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          remain_q <= remain_q - 1'b1;
          if (remain_q == 16'd1) begin
            state_q <= ST_IDLE;
          end else if (nwait_q != '0) begin
            state_q <= ST_WAIT;
            wait_q  <= nwait_q;
          end
        end
        ST_WAIT: begin
          wait_q <= wait_q - 1'b1;
          if (wait_q == 16'd1) state_q <= ST_ISSUE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Line of the next request, one stride ahead
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      engine_q <= head_i.engine;
      stride_q <= head_cfg.stride;
      nwait_q  <= head_cfg.nwait;
      line_q   <= head_i.base_line + LINE_W'(head_cfg.stride);
    end else if (state_q == ST_ISSUE) begin
      line_q <= line_q + LINE_W'(stride_q);
    end
  end

  assign busy_o = (state_q != ST_IDLE) ? (NR_ENGINES'(1) << engine_q) : '0;

  assign pf_req_o.valid  = (state_q == ST_ISSUE);
  assign pf_req_o.engine = engine_q;
  assign pf_req_o.line   = line_q;

  a_req_line_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pf_req_o.valid |-> !$isunknown(pf_req_o.line)
  ) else $error("prefetch request with unknown line address");

endmodule

//--- verilog/hwpf_top.sv
/*
 * Hardware stride prefetcher top level
 * Configuration registers, snoop matcher, trigger queue and sequencer,
 * with the status word packed from busy mask, occupancy and drop count
 */
`timescale 1ns/10ps

module hwpf_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  hwpf_pkg::cfg_wr_t                              cfg_wr_i,
  input  hwpf_pkg::snoop_t                               snoop_ld_i,
  input  hwpf_pkg::snoop_t                               snoop_st_i,
  output hwpf_pkg::cfg_word_u [hwpf_pkg::NR_ENGINES-1:0] cfg_base_o,
  output hwpf_pkg::cfg_word_u [hwpf_pkg::NR_ENGINES-1:0] cfg_param_o,
  output hwpf_pkg::cfg_word_u [hwpf_pkg::NR_ENGINES-1:0] cfg_throttle_o,
  output logic [63:0]                                    status_o,
  output hwpf_pkg::pf_req_t                              pf_req_o
);
  import hwpf_pkg::*;

  engine_cfg_t [NR_ENGINES-1:0] engine_cfg;
  logic                         trig_valid;
  trigger_t                     trig;
  trigger_t                     head;
  logic                         empty;
  logic                         pop;
  logic [FIFO_CNT_W-1:0]        fifo_count;
  logic [DROP_CNT_W-1:0]        drop_cnt;
  logic [NR_ENGINES-1:0]        busy;

  hwpf_csr u_csr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_wr_i     (cfg_wr_i),
    .base_o       (cfg_base_o),
    .param_o      (cfg_param_o),
    .throttle_o   (cfg_throttle_o),
    .engine_cfg_o (engine_cfg)
  );

  hwpf_snoop u_snoop (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .snoop_ld_i   (snoop_ld_i),
    .snoop_st_i   (snoop_st_i),
    .engine_cfg_i (engine_cfg),
    .trig_valid_o (trig_valid),
    .trig_o       (trig)
  );

  hwpf_trigger_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (trig_valid),
    .push_data_i (trig),
    .pop_i       (pop),
    .head_o      (head),
    .empty_o     (empty),
    .count_o     (fifo_count),
    .drop_cnt_o  (drop_cnt)
  );

  hwpf_sequencer u_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .empty_i      (empty),
    .pop_o        (pop),
    .engine_cfg_i (engine_cfg),
    .busy_o       (busy),
    .pf_req_o     (pf_req_o)
  );

  // Busy mask 3:0, occupancy 10:8, drops 23:16
  always_comb begin
    status_o                 = '0;
    status_o[NR_ENGINES-1:0] = busy;
    status_o[10:8]           = fifo_count;
    status_o[23:16]          = drop_cnt;
  end

endmodule

//--- verification/hwpf_tb.sv
/*
 * Testbench for the hardware stride prefetcher
 * Applies a table of config writes, snoops and idle runs, predicts the
 * prefetch requests from the engine settings and checks every request,
 * its spacing and the busy mask, plus readback, occupancy and drop count.
 */
`timescale 1ns/10ps

module hwpf_tb;
  import hwpf_pkg::*;

  typedef enum logic [3:0] {
    OP_WRITE, OP_LOAD, OP_STORE, OP_DUAL, OP_IDLE, OP_RANDOM, OP_READBACK, OP_DROPS, OP_END
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [1:0]  eng;
    cfg_kind_e   kind;
    logic [63:0] data;
    logic [31:0] addr;
    logic [31:0] addr2;
    logic [15:0] n;
    logic        abort;
    logic        lost;
  } step_t;

  typedef struct packed {
    logic [ENGINE_ID_W-1:0] eng;
    logic [LINE_W-1:0]      line;
    logic [16:0]            gap;
  } exp_req_t;

  localparam int          NR_TESTS   = 6;
  localparam int          MARGIN     = 2000;
  localparam int          RST_CYCLES = 16;
  localparam logic [31:0] SEED       = 32'h1d59_6344;
  localparam logic [63:0] BASE_MASK  = 64'h0000_0000_FFFF_FFC1;
  localparam logic [63:0] PARAM_MASK = 64'h0000_0000_FFFF_FFFF;
  localparam logic [63:0] THR_MASK   = 64'h0000_0000_0000_FFFF;
  localparam logic [31:0] E0_ADDR    = 32'h0040_0000;
  localparam logic [31:0] E1_ADDR    = 32'h0080_0040;
  // Near the top of the line space so the stride wraps
  localparam logic [31:0] E2_ADDR    = 32'hFFFF_FF80;
  localparam logic [31:0] E3_ADDR    = 32'h0100_00C0;

  logic                         clk_i;
  logic                         rst_ni;
  cfg_wr_t                      cfg_wr;
  snoop_t                       snoop_ld;
  snoop_t                       snoop_st;
  cfg_word_u [NR_ENGINES-1:0]   cfg_base;
  cfg_word_u [NR_ENGINES-1:0]   cfg_param;
  cfg_word_u [NR_ENGINES-1:0]   cfg_throttle;
  logic [63:0]                  status;
  pf_req_t                      pf_req;

  step_t       table_q[$];
  exp_req_t    exp_q[$];
  logic [63:0] m_base[NR_ENGINES];
  logic [63:0] m_param[NR_ENGINES];
  logic [63:0] m_thr[NR_ENGINES];
  int          cycle = 0;
  int          wd_cycles = 0;
  int          limit = 0;
  int          last_req = 0;
  int          test_errs = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  int          cur_test = 1;

  hwpf_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_wr_i       (cfg_wr),
    .snoop_ld_i     (snoop_ld),
    .snoop_st_i     (snoop_st),
    .cfg_base_o     (cfg_base),
    .cfg_param_o    (cfg_param),
    .cfg_throttle_o (cfg_throttle),
    .status_o       (status),
    .pf_req_o       (pf_req)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    wd_cycles <= wd_cycles + 1;
    if (limit > 0 && wd_cycles > limit) begin
      $display("timeout: run went past %0d cycles without finishing", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic string test_name(input int t);
    case (t)
      1: return "reset and readback";
      2: return "single trigger";
      3: return "ports and filtering";
      4: return "queue order";
      5: return "overflow";
      default: return "zero lines";
    endcase
  endfunction

  // Register words with every unused bit set, to see them cleared
  function automatic logic [63:0] base_word(input logic [31:0] addr, input logic en);
    return {32'hA5A5_5A5A, addr[31:6], 5'h1F, en};
  endfunction

  function automatic logic [63:0] param_word(input logic [15:0] nl, input logic [15:0] st);
    return {32'hDEAD_BEEF, nl, st};
  endfunction

  function automatic logic [63:0] throttle_word(input logic [15:0] nw);
    return {48'hC3C3_3C3C_0F0F, nw};
  endfunction

  task automatic flag_mismatch(input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("MISMATCH %s: got 0x%h expected 0x%h at cycle %0d", sig, got, exp, cycle);
    test_errs++;
  endtask

  task automatic write_step(input int eng, input cfg_kind_e kind, input logic [63:0] data);
    step_t s;
    s = '0;
    s.op = OP_WRITE;
    s.eng = 2'(eng);
    s.kind = kind;
    s.data = data;
    table_q.push_back(s);
  endtask

  task automatic load_step(input logic [31:0] addr, input logic abort, input logic lost);
    step_t s;
    s = '0;
    s.op = OP_LOAD;
    s.addr = addr;
    s.abort = abort;
    s.lost = lost;
    table_q.push_back(s);
  endtask

  task automatic store_step(input logic [31:0] addr);
    step_t s;
    s = '0;
    s.op = OP_STORE;
    s.addr2 = addr;
    table_q.push_back(s);
  endtask

  task automatic dual_step(input logic [31:0] ld_addr, input logic [31:0] st_addr);
    step_t s;
    s = '0;
    s.op = OP_DUAL;
    s.addr = ld_addr;
    s.addr2 = st_addr;
    table_q.push_back(s);
  endtask

  task automatic idle_step(input step_t proto, input int n);
    step_t s;
    s = proto;
    s.n = 16'(n);
    table_q.push_back(s);
  endtask

  task automatic drain_step();
    step_t s;
    s = '0;
    s.op = OP_END;
    table_q.push_back(s);
  endtask

  function automatic step_t op_only(input op_e op);
    step_t s;
    s = '0;
    s.op = op;
    return s;
  endfunction

  task automatic build_table();
    // 1: write all registers of all engines, then read back
    write_step(0, CFG_BASE, base_word(E0_ADDR, 1'b1));
    write_step(0, CFG_PARAM, param_word(16'd3, 16'd1));
    write_step(0, CFG_THROTTLE, throttle_word(16'd2));
    write_step(1, CFG_BASE, base_word(E1_ADDR, 1'b1));
    write_step(1, CFG_PARAM, param_word(16'd4, 16'h0010));
    write_step(1, CFG_THROTTLE, throttle_word(16'd0));
    write_step(2, CFG_BASE, base_word(E2_ADDR, 1'b1));
    write_step(2, CFG_PARAM, param_word(16'd2, 16'd3));
    write_step(2, CFG_THROTTLE, throttle_word(16'd1));
    write_step(3, CFG_BASE, base_word(E3_ADDR, 1'b1));
    write_step(3, CFG_PARAM, param_word(16'd0, 16'd5));
    write_step(3, CFG_THROTTLE, throttle_word(16'd0));
    idle_step(op_only(OP_READBACK), 1);
    drain_step();
    // 2
    load_step(E0_ADDR + 32'h24, 1'b0, 1'b0);
    drain_step();
    // 3: abort, disabled engine, noise, store port, both ports at once
    load_step(E1_ADDR + 32'h8, 1'b1, 1'b0);
    write_step(1, CFG_BASE, base_word(E1_ADDR, 1'b0));
    load_step(E1_ADDR, 1'b0, 1'b0);
    write_step(1, CFG_BASE, base_word(E1_ADDR, 1'b1));
    idle_step(op_only(OP_RANDOM), 24);
    store_step(E2_ADDR + 32'h4);
    idle_step(op_only(OP_IDLE), 4);
    dual_step(E1_ADDR, E0_ADDR);
    idle_step(op_only(OP_READBACK), 1);
    drain_step();
    // 4
    load_step(E2_ADDR, 1'b0, 1'b0);
    load_step(E1_ADDR + 32'h10, 1'b0, 1'b0);
    store_step(E0_ADDR + 32'h3F);
    load_step(E1_ADDR + 32'h3C, 1'b0, 1'b0);
    drain_step();
    // 5: six triggers behind a slow one, the last two find the queue full
    write_step(0, CFG_THROTTLE, throttle_word(16'd30));
    load_step(E0_ADDR, 1'b0, 1'b0);
    idle_step(op_only(OP_IDLE), 4);
    load_step(E1_ADDR, 1'b0, 1'b0);
    load_step(E2_ADDR, 1'b0, 1'b0);
    load_step(E1_ADDR, 1'b0, 1'b0);
    load_step(E2_ADDR, 1'b0, 1'b0);
    load_step(E1_ADDR, 1'b0, 1'b1);
    load_step(E2_ADDR, 1'b0, 1'b1);
    idle_step(op_only(OP_IDLE), 3);
    idle_step(op_only(OP_DROPS), 2);
    drain_step();
    // 6
    load_step(E3_ADDR, 1'b0, 1'b0);
    load_step(E2_ADDR + 32'h3F, 1'b0, 1'b0);
    drain_step();
  endtask

  function automatic int table_cycles();
    int sum;
    sum = 0;
    foreach (table_q[i]) begin
      if (table_q[i].op == OP_IDLE || table_q[i].op == OP_RANDOM) sum += int'(table_q[i].n);
      else if (table_q[i].op == OP_END) sum += 7;
      else sum += 1;
    end
    return sum;
  endfunction

  task automatic model_write(input logic [1:0] eng, input cfg_kind_e kind,
                             input logic [63:0] data);
    case (kind)
      CFG_BASE:     m_base[eng] = data & BASE_MASK;
      CFG_PARAM:    m_param[eng] = data & PARAM_MASK;
      CFG_THROTTLE: m_thr[eng] = data & THR_MASK;
      default: ;
    endcase
  endtask

  // Load port first, then lowest enabled engine whose base line matches
  task automatic predict_requests(input snoop_t ld, input snoop_t st, input logic lost);
    logic              found;
    int                eng;
    int                nl;
    logic [LINE_W-1:0] line;
    logic [15:0]       stride;
    logic [16:0]       gap;
    exp_req_t          r;
    found = 1'b0;
    eng = 0;
    line = '0;
    for (int e = 0; e < NR_ENGINES; e++) begin
      if (!found && ld.valid && !ld.abort && m_base[e][0] &&
          ld.addr[31:6] == m_base[e][31:6]) begin
        found = 1'b1;
        eng = e;
        line = ld.addr[31:6];
      end
    end
    for (int e = 0; e < NR_ENGINES; e++) begin
      if (!found && st.valid && !st.abort && m_base[e][0] &&
          st.addr[31:6] == m_base[e][31:6]) begin
        found = 1'b1;
        eng = e;
        line = st.addr[31:6];
      end
    end
    if (found && !lost) begin
      nl = int'(m_param[eng][31:16]);
      stride = m_param[eng][15:0];
      gap = 17'(m_thr[eng][15:0]) + 17'd1;
      for (int k = 1; k <= nl; k++) begin
        r.eng = ENGINE_ID_W'(eng);
        r.line = line + LINE_W'(k) * LINE_W'(stride);
        r.gap = (k == 1) ? 17'd0 : gap;
        exp_q.push_back(r);
      end
    end
  endtask

  function automatic logic [31:0] miss_addr();
    logic [31:0] a;
    logic        clash;
    do begin
      a = $urandom;
      clash = 1'b0;
      for (int e = 0; e < NR_ENGINES; e++) begin
        if (a[31:6] == m_base[e][31:6]) clash = 1'b1;
      end
    end while (clash);
    return a;
  endfunction

  task automatic check_request();
    exp_req_t r;
    if (pf_req.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: unexpected prefetch request, engine %0d line 0x%h at cycle %0d",
                 pf_req.engine, pf_req.line, cycle);
        test_errs++;
      end else begin
        r = exp_q.pop_front();
        if (pf_req.engine !== r.eng) begin
          flag_mismatch("pf_req_o.engine", 64'(pf_req.engine), 64'(r.eng));
        end
        if (pf_req.line !== r.line) begin
          flag_mismatch("pf_req_o.line", 64'(pf_req.line), 64'(r.line));
        end
        if (r.gap != 17'd0 && 17'(cycle - last_req) != r.gap) begin
          flag_mismatch("pf_req_o spacing", 64'(cycle - last_req), 64'(r.gap));
        end
        if (status[NR_ENGINES-1:0] !== (NR_ENGINES'(1) << r.eng)) begin
          flag_mismatch("status_o.busy", 64'(status[NR_ENGINES-1:0]),
                        64'(NR_ENGINES'(1) << r.eng));
        end
      end
      last_req = cycle;
    end
  endtask

  // Requests are sampled mid-cycle, inputs change just after the edge
  task automatic next_cycle();
    @(negedge clk_i);
    check_request();
    @(posedge clk_i);
    #2;
    cycle++;
    cfg_wr = '0;
    snoop_ld = '0;
    snoop_st = '0;
  endtask

  task automatic compare_readback();
    for (int e = 0; e < NR_ENGINES; e++) begin
      if (cfg_base[e] !== m_base[e]) begin
        flag_mismatch($sformatf("cfg_base_o[%0d]", e), cfg_base[e], m_base[e]);
      end
      if (cfg_param[e] !== m_param[e]) begin
        flag_mismatch($sformatf("cfg_param_o[%0d]", e), cfg_param[e], m_param[e]);
      end
      if (cfg_throttle[e] !== m_thr[e]) begin
        flag_mismatch($sformatf("cfg_throttle_o[%0d]", e), cfg_throttle[e], m_thr[e]);
      end
    end
  endtask

  task automatic close_test();
    repeat (3) next_cycle();
    while (exp_q.size() != 0 || status[3:0] != 4'd0 || status[10:8] != 3'd0) next_cycle();
    repeat (4) next_cycle();
    if (test_errs == 0) begin
      $display("test %0d (%s): ok", cur_test, test_name(cur_test));
      tests_pass++;
    end else begin
      $display("test %0d (%s): failed with %0d errors", cur_test, test_name(cur_test), test_errs);
      tests_fail++;
    end
    test_errs = 0;
    cur_test++;
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_WRITE: begin
        next_cycle();
        cfg_wr.valid = 1'b1;
        cfg_wr.engine = s.eng;
        cfg_wr.kind = s.kind;
        cfg_wr.data = s.data;
        model_write(s.eng, s.kind, s.data);
      end
      OP_LOAD, OP_STORE, OP_DUAL: begin
        next_cycle();
        snoop_ld.valid = (s.op != OP_STORE);
        snoop_ld.abort = s.abort;
        snoop_ld.addr = s.addr;
        snoop_st.valid = (s.op != OP_LOAD);
        snoop_st.addr = s.addr2;
        predict_requests(snoop_ld, snoop_st, s.lost);
      end
      OP_IDLE: repeat (int'(s.n)) next_cycle();
      OP_RANDOM: begin
        repeat (int'(s.n)) begin
          next_cycle();
          snoop_ld.valid = 1'b1;
          snoop_ld.addr = miss_addr();
          snoop_st.valid = 1'b1;
          snoop_st.addr = miss_addr();
        end
      end
      OP_READBACK: begin
        next_cycle();
        compare_readback();
      end
      OP_DROPS: begin
        next_cycle();
        if (status[23:16] !== s.n[7:0]) begin
          flag_mismatch("status_o.drops", 64'(status[23:16]), 64'(s.n[7:0]));
        end
        // Queue still full behind the slow trigger
        if (status[10:8] !== 3'(FIFO_DEPTH)) begin
          flag_mismatch("status_o.occupancy", 64'(status[10:8]), 64'(FIFO_DEPTH));
        end
      end
      default: close_test();
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni = 1'b0;
    cfg_wr = '0;
    snoop_ld = '0;
    snoop_st = '0;
    for (int e = 0; e < NR_ENGINES; e++) begin
      m_base[e] = '0;
      m_param[e] = '0;
      m_thr[e] = '0;
    end
    build_table();
    limit = RST_CYCLES + table_cycles() + MARGIN;
    repeat (RST_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Everything reads zero out of reset
    if (pf_req.valid !== 1'b0) flag_mismatch("pf_req_o.valid", 64'(pf_req.valid), 64'd0);
    if (status !== 64'd0) flag_mismatch("status_o", status, 64'd0);
    compare_readback();
    foreach (table_q[i]) run_step(table_q[i]);
    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && tests_pass == NR_TESTS) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/hwpf_pkg.sv
verilog/hwpf_csr.sv
verilog/hwpf_snoop.sv
verilog/hwpf_trigger_fifo.sv
verilog/hwpf_sequencer.sv
verilog/hwpf_top.sv
verification/hwpf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the prefetcher testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module hwpf_tb -f verilog.f -o hwpf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/hwpf_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
